//--- Makefile
# Verilator build of the predictor testbench, pass or fail is read from sim.log

SOURCES := $(shell cat src.f)

obj_dir/VbpredTb: src.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/100ps --top-module bpredTb -f src.f

run: obj_dir/VbpredTb
	./obj_dir/VbpredTb | tee sim.log
	grep -qx 'Test OK' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- common/bpredPkg.sv
// Counter type and helper functions shared by the predictor and its table
// Counters are 2 bits wide and saturate at 0 and 3
`default_nettype none

package bpredPkg;

  // Width of a fetch PC
  localparam int PcWidth = 32;

  // Saturating direction counter where 0 is strongly not-taken and 3 strongly taken
  typedef logic [1:0] counterT;

  // Entries that were never written read as weakly not-taken
  localparam counterT CounterInit = 2'd1;

  // Step a counter one place toward the resolved outcome
  function automatic counterT nextCounter(input counterT count, input logic taken);
    counterT result;
    if (taken) begin
      result = (count == 2'd3) ? count : count + 2'd1;
    end else begin
      result = (count == 2'd0) ? count : count - 2'd1;
    end
    return result;
  endfunction

  // The high bit alone gives the predicted direction
  function automatic logic counterTaken(input counterT count);
    return count[1];
  endfunction

endpackage

`default_nettype wire

//--- common/predictUpdateIf.sv
// Read index and write port of the pattern history table
// IndexBits must equal the history length used by the predictor
`default_nettype none

interface predictUpdateIf
  import bpredPkg::*;
  #(parameter int IndexBits = 10)
  ();

  // Write of one resolved counter
  logic                 writeEn;
  logic [IndexBits-1:0] writeIndex;
  counterT              writeCounter;

  // Index of the lookup being read this cycle
  logic [IndexBits-1:0] readIndex;

  // The predictor owns every signal of the bundle
  modport predictor (
    output writeEn,
    output writeIndex,
    output writeCounter,
    output readIndex
  );

  // The table only consumes them
  modport tableSide (
    input writeEn,
    input writeIndex,
    input writeCounter,
    input readIndex
  );

endinterface

`default_nettype wire

//--- design/bpredUnit.sv
// Branch direction predictor top level with a gshare or plain global history index
// Updates resolve the oldest delivered branch and must not exceed those delivered
`default_nettype none

module bpredUnit
  import bpredPkg::*;
  #(parameter int HistoryBits   = 10,
    parameter int UseGshare     = 1,
    parameter int InFlightDepth = 8,
    parameter int Credits       = 4)
  (input  logic               clk,
   input  logic               reset,
   input  logic               lookupValid,
   input  logic [PcWidth-1:0] lookupPc,
   output logic               lookupReady,
   output logic               fetchValid,
   output logic               fetchTaken,
   output counterT            fetchCounter,
   input  logic               creditReturn,
   input  logic               updateValid,
   input  logic               updateTaken);

  localparam int CountBits = $clog2(InFlightDepth + 1);

  logic                 acceptLookup;
  logic [PcWidth-1:0]   acceptPc;
  logic [CountBits-1:0] inFlightCount;
  logic [CountBits-1:0] queueFree;
  logic                 predValid;
  counterT              predCounter;
  counterT              readCounter;

  // Table read index and write port
  predictUpdateIf #(.IndexBits(HistoryBits)) phtBus ();

  lookupAdmit #(.InFlightDepth(InFlightDepth)) admit_i (
    .clk(clk), .reset(reset), .lookupValid(lookupValid), .lookupPc(lookupPc),
    .lookupReady(lookupReady), .acceptLookup(acceptLookup), .acceptPc(acceptPc),
    .inFlightCount(inFlightCount), .queueFree(queueFree));

  globalHistoryPredictor #(
    .HistoryBits(HistoryBits), .UseGshare(UseGshare), .InFlightDepth(InFlightDepth)
  ) predictor_i (
    .clk(clk), .reset(reset), .acceptLookup(acceptLookup), .acceptPc(acceptPc),
    .updateValid(updateValid), .updateTaken(updateTaken), .predValid(predValid),
    .predCounter(predCounter), .inFlightCount(inFlightCount), .tbl(phtBus.predictor),
    .readCounter(readCounter));

  phtRam #(.HistoryBits(HistoryBits)) pht_i (
    .clk(clk), .reset(reset), .tbl(phtBus.tableSide), .readCounter(readCounter));

  predictionQueue #(.InFlightDepth(InFlightDepth), .Credits(Credits)) queue_i (
    .clk(clk), .reset(reset), .predValid(predValid), .predCounter(predCounter),
    .queueFree(queueFree), .fetchValid(fetchValid), .fetchTaken(fetchTaken),
    .fetchCounter(fetchCounter), .creditReturn(creditReturn));

endmodule

`default_nettype wire

//--- design/lookupAdmit.sv
// Input side of the predictor that admits lookups under back-pressure
// Ready stays low in the first cycle after reset is released
`default_nettype none

module lookupAdmit
  import bpredPkg::*;
  #(parameter int InFlightDepth = 8)
  (input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 lookupValid,
   input  logic [PcWidth-1:0]                   lookupPc,
   output logic                                 lookupReady,
   output logic                                 acceptLookup,
   output logic [PcWidth-1:0]                   acceptPc,
   input  logic [$clog2(InFlightDepth + 1)-1:0] inFlightCount,
   input  logic [$clog2(InFlightDepth + 1)-1:0] queueFree);

  localparam int CountBits = $clog2(InFlightDepth + 1);

  // Set from the first edge after reset
  logic live;
  // A lookup accepted last cycle whose table read is not yet in the queue
  logic inRead;
  logic roomInFlight;
  logic roomInQueue;

  always_ff @(posedge clk) begin
    if (reset) begin
      live   <= 1'b0;
      inRead <= 1'b0;
    end else begin
      live   <= 1'b1;
      inRead <= acceptLookup;
    end
  end

  // Unresolved branches are bounded by the record FIFO depth
  assign roomInFlight = inFlightCount < CountBits'(InFlightDepth);

  // One slot for the lookup in the read stage and one for the new lookup
  assign roomInQueue = queueFree > CountBits'(inRead);

  assign lookupReady  = live && roomInFlight && roomInQueue;
  assign acceptLookup = lookupValid && lookupReady;

  // The table read registers the index, so the PC goes straight to the predictor
  assign acceptPc = lookupPc;

endmodule

`default_nettype wire

//--- design/predictionQueue.sv
// Output side holding a prediction FIFO that is sent to fetch under credit flow control
// Fetch has no ready signal, so every cycle with fetchValid high is one beat
`default_nettype none

module predictionQueue
  import bpredPkg::*;
  #(parameter int InFlightDepth = 8,
    parameter int Credits       = 4)
  (input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 predValid,
   input  counterT                              predCounter,
   output logic [$clog2(InFlightDepth + 1)-1:0] queueFree,
   output logic                                 fetchValid,
   output logic                                 fetchTaken,
   output counterT                              fetchCounter,
   input  logic                                 creditReturn);

  localparam int PtrBits    = (InFlightDepth > 1) ? $clog2(InFlightDepth) : 1;
  localparam int CountBits  = $clog2(InFlightDepth + 1);
  localparam int CreditBits = $clog2(Credits + 1);

  counterT               slotMem [InFlightDepth];
  logic [PtrBits-1:0]    headPtr;
  logic [PtrBits-1:0]    tailPtr;
  logic [CountBits-1:0]  fill;
  logic [CreditBits-1:0] creditCount;

  ////////////////////////////////////////
  // Prediction FIFO
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (predValid) begin
      slotMem[tailPtr] <= predCounter;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      headPtr <= '0;
      tailPtr <= '0;
      fill    <= '0;
    end else begin
      if (predValid) begin
        tailPtr <= (tailPtr == PtrBits'(InFlightDepth - 1)) ? '0 : tailPtr + PtrBits'(1);
      end
      if (fetchValid) begin
        headPtr <= (headPtr == PtrBits'(InFlightDepth - 1)) ? '0 : headPtr + PtrBits'(1);
      end
      unique case ({predValid, fetchValid})
        2'b10:   fill <= fill + CountBits'(1);
        2'b01:   fill <= fill - CountBits'(1);
        default: fill <= fill;
      endcase
    end
  end

  assign queueFree = CountBits'(InFlightDepth) - fill;

  ////////////////////////////////////////
  // Credits and delivery
  ////////////////////////////////////////

  // Fetch starts with every credit, each beat spends one and each return adds one
  always_ff @(posedge clk) begin
    if (reset) begin
      creditCount <= CreditBits'(Credits);
    end else begin
      unique case ({fetchValid, creditReturn})
        2'b10:   creditCount <= creditCount - CreditBits'(1);
        2'b01:   creditCount <= creditCount + CreditBits'(1);
        default: creditCount <= creditCount;
      endcase
    end
  end

  // The head goes out whenever a credit is held
  assign fetchValid   = (fill != '0) && (creditCount != '0);
  assign fetchCounter = slotMem[headPtr];
  assign fetchTaken   = counterTaken(fetchCounter);

endmodule

`default_nettype wire

//--- globalHistory/globalHistoryPredictor.sv
// Global history predictor with an in-order record of every lookup in flight
// Updates must arrive in lookup order and only for branches already delivered
// HistoryBits must be at least 2 and below PcWidth - 2
`default_nettype none

module globalHistoryPredictor
  import bpredPkg::*;
  #(parameter int HistoryBits   = 10,
    parameter int UseGshare     = 1,
    parameter int InFlightDepth = 8)
  (input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 acceptLookup,
   input  logic [PcWidth-1:0]                   acceptPc,
   input  logic                                 updateValid,
   input  logic                                 updateTaken,
   output logic                                 predValid,
   output counterT                              predCounter,
   output logic [$clog2(InFlightDepth + 1)-1:0] inFlightCount,
   predictUpdateIf.predictor                    tbl,
   input  counterT                              readCounter);

  localparam int PtrBits   = (InFlightDepth > 1) ? $clog2(InFlightDepth) : 1;
  localparam int CountBits = $clog2(InFlightDepth + 1);

  logic [HistoryBits-1:0] ghr;
  logic [HistoryBits-1:0] lookupIndex;
  logic [HistoryBits-1:0] resolvedIndex;
  counterT                resolvedCounter;

  // Record FIFO holding the index written at lookup and the counter one cycle later
  logic [HistoryBits-1:0] indexMem [InFlightDepth];
  counterT                counterMem [InFlightDepth];
  logic [PtrBits-1:0]     headPtr;
  logic [PtrBits-1:0]     tailPtr;
  logic [PtrBits-1:0]     readSlot;
  logic [CountBits-1:0]   recordCount;

  // Registered result of the read and write index compare
  logic                   forwardHit;
  counterT                forwardCounter;

  ////////////////////////////////////////
  // Index forming
  ////////////////////////////////////////

  // Gshare mixes the word address bits of the PC into the history
  assign lookupIndex = (UseGshare != 0) ? (ghr ^ acceptPc[HistoryBits+1:2]) : ghr;

  // The oldest record is the branch being resolved
  assign resolvedIndex   = indexMem[headPtr];
  assign resolvedCounter = nextCounter(counterMem[headPtr], updateTaken);

  assign tbl.readIndex    = lookupIndex;
  assign tbl.writeEn      = updateValid;
  assign tbl.writeIndex   = resolvedIndex;
  assign tbl.writeCounter = resolvedCounter;

  // Newest outcome enters at the top bit
  always_ff @(posedge clk) begin
    if (reset) begin
      ghr <= '0;
    end else if (updateValid) begin
      ghr <= {updateTaken, ghr[HistoryBits-1:1]};
    end
  end

  ////////////////////////////////////////
  // Record FIFO
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (acceptLookup) begin
      indexMem[tailPtr] <= lookupIndex;
      readSlot          <= tailPtr;
    end
    // The counter lands in the slot its index took a cycle earlier
    if (predValid) begin
      counterMem[readSlot] <= predCounter;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      headPtr     <= '0;
      tailPtr     <= '0;
      recordCount <= '0;
    end else begin
      if (acceptLookup) begin
        tailPtr <= (tailPtr == PtrBits'(InFlightDepth - 1)) ? '0 : tailPtr + PtrBits'(1);
      end
      if (updateValid) begin
        headPtr <= (headPtr == PtrBits'(InFlightDepth - 1)) ? '0 : headPtr + PtrBits'(1);
      end
      unique case ({acceptLookup, updateValid})
        2'b10:   recordCount <= recordCount + CountBits'(1);
        2'b01:   recordCount <= recordCount - CountBits'(1);
        default: recordCount <= recordCount;
      endcase
    end
  end

  assign inFlightCount = recordCount;

  ////////////////////////////////////////
  // Read stage and forwarding
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      predValid  <= 1'b0;
      forwardHit <= 1'b0;
    end else begin
      predValid  <= acceptLookup;
      forwardHit <= updateValid && (lookupIndex == resolvedIndex);
    end
  end

  always_ff @(posedge clk) begin
    forwardCounter <= resolvedCounter;
  end

  // The table still holds the old value when both ports hit one entry
  assign predCounter = forwardHit ? forwardCounter : readCounter;

endmodule

`default_nettype wire

//--- globalHistory/phtRam.sv
// Pattern history table with one synchronous read and one write port
// A read of the entry written in the same cycle returns the old value
`default_nettype none

module phtRam
  import bpredPkg::*;
  #(parameter int HistoryBits = 10)
  (input  logic                  clk,
   input  logic                  reset,
   predictUpdateIf.tableSide     tbl,
   output counterT               readCounter);

  localparam int Entries = 1 << HistoryBits;

  counterT            counterMem [Entries];
  // One bit per entry that is set once the entry holds a written counter
  logic [Entries-1:0] entryValid;

  always_ff @(posedge clk) begin
    if (reset) begin
      entryValid <= '0;
    end else if (tbl.writeEn) begin
      entryValid[tbl.writeIndex] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tbl.writeEn) begin
      counterMem[tbl.writeIndex] <= tbl.writeCounter;
    end
  end

  // Registered read
  // Unwritten entries report the init value whatever the array holds
  always_ff @(posedge clk) begin
    if (entryValid[tbl.readIndex]) begin
      readCounter <= counterMem[tbl.readIndex];
    end else begin
      readCounter <= CounterInit;
    end
  end

endmodule

`default_nettype wire

//--- src.f
common/bpredPkg.sv
common/predictUpdateIf.sv
globalHistory/phtRam.sv
globalHistory/globalHistoryPredictor.sv
design/lookupAdmit.sv
design/predictionQueue.sv
design/bpredUnit.sv
verification/bpredChecker.sv
verification/bpredTb.sv

//--- verification/bpredChecker.sv
// Reference model of the predictor that watches the top-level ports
// Inputs and outputs are sampled at the falling edge, half a cycle before the edge that takes them
// Updates must only resolve branches already delivered to fetch
`default_nettype none

module bpredChecker
  import bpredPkg::*;
  #(parameter int HistoryBits   = 10,
    parameter int UseGshare     = 1,
    parameter int InFlightDepth = 8,
    parameter int Credits       = 4)
  (input  logic               clk,
   input  logic               reset,
   input  logic               lookupValid,
   input  logic [PcWidth-1:0] lookupPc,
   input  logic               lookupReady,
   input  logic               fetchValid,
   input  logic               fetchTaken,
   input  counterT            fetchCounter,
   input  logic               creditReturn,
   input  logic               updateValid,
   input  logic               updateTaken,
   input  int                 testId,
   input  logic               testEnd,
   output int                 errorCount,
   output int                 checkCount,
   output int                 pending);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int Entries = 1 << HistoryBits;

  // Model state holds the table, history, in-order records and predictions owed to fetch
  counterT                modelPht [Entries];
  logic [HistoryBits-1:0] modelGhr;
  logic [HistoryBits-1:0] recIndex [$];
  counterT                recCounter [$];
  counterT                expCounter [$];
  int                     expCycle [$];
  int                     creditsHeld;
  logic                   firstCycle = 1'b1;

  int cycle          = 0;
  int errors         = 0;
  int checks         = 0;
  int testChecks     = 0;
  int testErrors     = 0;
  int forwardHits    = 0;
  int readyLowCycles = 0;
  int topBeats       = 0;
  int bottomBeats    = 0;

  assign errorCount = errors;
  assign checkCount = checks;

  // Saturating step of a 2-bit counter toward the outcome
  function automatic counterT stepCounter(input counterT count, input logic taken);
    if (taken) begin
      return (count == 2'd3) ? count : count + 2'd1;
    end
    return (count == 2'd0) ? count : count - 2'd1;
  endfunction

  // Gshare folds the PC word address into the history
  function automatic logic [HistoryBits-1:0] tableIndex(input logic [PcWidth-1:0] pc,
                                                       input logic [HistoryBits-1:0] hist);
    return (UseGshare != 0) ? (hist ^ pc[HistoryBits+1:2]) : hist;
  endfunction

  function automatic string testName(input int id);
    case (id)
      1:       return "reset and initial counters";
      2:       return "random lookups and updates";
      3:       return "counter saturation";
      4:       return "same-cycle forwarding";
      5:       return "credit back-pressure";
      6:       return "alternating history";
      default: return "unnamed";
    endcase
  endfunction

  task automatic countCheck();
    checks++;
    testChecks++;
  endtask

  // Wrong value seen on a DUT port
  task automatic mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    errors++;
    testErrors++;
  endtask

  // Anything else that went wrong
  task automatic problem(input string msg);
    $display("Problem at %0t ns: %s", $time, msg);
    errors++;
    testErrors++;
  endtask

  task automatic finishTest();
    countCheck();
    if (expCounter.size() != 0) begin
      problem($sformatf("%0d predictions never reached fetch", expCounter.size()));
    end
    if (recIndex.size() != 0) begin
      problem($sformatf("%0d branches were left unresolved", recIndex.size()));
    end
    if (creditsHeld != Credits) begin
      problem($sformatf("fetch ended with %0d credits instead of %0d", creditsHeld, Credits));
    end
    if (testId == 3 && (topBeats == 0 || bottomBeats == 0)) begin
      problem("the counters never reached both 3 and 0 during the saturation phases");
    end
    if (testId == 4 && forwardHits == 0) begin
      problem("no lookup met an update of the same entry in one cycle");
    end
    if (testId == 5 && readyLowCycles == 0) begin
      problem("lookupReady never fell while credits were withheld");
    end
    $display("Result of test %0d, %s: %0d checks, %0d errors, %s", testId, testName(testId),
             testChecks, testErrors, (testErrors == 0) ? "passed" : "failed");
    testChecks     = 0;
    testErrors     = 0;
    forwardHits    = 0;
    readyLowCycles = 0;
    topBeats       = 0;
    bottomBeats    = 0;
  endtask

  ////////////////////////////////////////
  // Model step once per clock edge
  ////////////////////////////////////////

  always @(negedge clk) begin : modelStep
    logic [HistoryBits-1:0] readIndex;
    logic [HistoryBits-1:0] writeIndex;
    logic                   wrote;
    logic                   wantReady;
    counterT                want;
    int                     born;
    cycle++;
    wrote      = 1'b0;
    writeIndex = '0;
    if (reset) begin
      countCheck();
      if (lookupReady || fetchValid) begin
        mismatch($sformatf("lookupReady %0b fetchValid %0b in reset, expected 0 0",
                           lookupReady, fetchValid));
      end
      modelGhr = '0;
      foreach (modelPht[i]) begin
        modelPht[i] = CounterInit;
      end
      recIndex.delete();
      recCounter.delete();
      expCounter.delete();
      expCycle.delete();
      creditsHeld = Credits;
      firstCycle  = 1'b1;
    end else begin
      // Ready follows the unresolved count before this cycle's update frees a record
      // The first cycle after reset is not modelled while the admit side comes out of reset
      if (!firstCycle) begin
        countCheck();
        wantReady = recIndex.size() < InFlightDepth;
        if (lookupReady !== wantReady) begin
          mismatch($sformatf("lookupReady %0b with %0d branches unresolved, expected %0b",
                             lookupReady, recIndex.size(), wantReady));
        end
      end
      firstCycle = 1'b0;
      // The update lands before a lookup of the same cycle reads the table
      if (updateValid) begin
        if (recIndex.size() == 0) begin
          problem("an update arrived with no branch in flight");
        end else begin
          writeIndex           = recIndex.pop_front();
          modelPht[writeIndex] = stepCounter(recCounter.pop_front(), updateTaken);
          wrote                = 1'b1;
        end
      end
      if (lookupValid && lookupReady) begin
        readIndex = tableIndex(lookupPc, modelGhr);
        recIndex.push_back(readIndex);
        recCounter.push_back(modelPht[readIndex]);
        expCounter.push_back(modelPht[readIndex]);
        expCycle.push_back(cycle);
        if (wrote && readIndex == writeIndex) begin
          forwardHits++;
        end
      end
      if (lookupValid && !lookupReady) begin
        readyLowCycles++;
      end
      // The lookup above still used the history from before this update
      if (updateValid) begin
        modelGhr = {updateTaken, modelGhr[HistoryBits-1:1]};
      end
      if (fetchValid) begin
        countCheck();
        if (creditsHeld == 0) begin
          mismatch("fetchValid high with no credit held");
        end
        creditsHeld--;
        if (expCounter.size() == 0) begin
          problem("a fetch beat came with no prediction outstanding");
        end else begin
          want = expCounter.pop_front();
          born = expCycle.pop_front();
          if (want == 2'd3) begin
            topBeats++;
          end
          if (want == 2'd0) begin
            bottomBeats++;
          end
          if (fetchCounter !== want || fetchTaken !== want[1]) begin
            mismatch($sformatf("fetch counter %0d taken %0b, expected %0d taken %0b",
                               fetchCounter, fetchTaken, want, want[1]));
          end
          // Table read at the lookup edge and queue write one edge later
          if (cycle < born + 2) begin
            mismatch($sformatf("beat %0d cycles after its lookup, expected at least 2",
                               cycle - born));
          end
        end
      end
      if (creditReturn) begin
        creditsHeld++;
      end
    end
    if (testEnd) begin
      finishTest();
    end
    pending = expCounter.size();
  end

endmodule

`default_nettype wire

//--- verification/bpredTb.sv
// Testbench for the branch predictor with random lookups, updates and credit returns
// Inputs change 1 ns after the rising edge and bpredChecker compares every fetch beat
`default_nettype none

module bpredTb
  import bpredPkg::*;
  ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HistoryBits   = 10;
  localparam int UseGshare     = 1;
  localparam int InFlightDepth = 8;
  localparam int Credits       = 4;

  // Test lengths in cycles also size the watchdog
  localparam int ShortCycles   = 30;
  localparam int RandomCycles  = 600;
  localparam int PhaseCycles   = 60;
  localparam int ForwardRounds = 6;
  localparam int WaitLimit     = 20;
  localparam int DrainLimit    = 100;
  localparam int TotalCycles   = 8 + ShortCycles + RandomCycles + 8 * PhaseCycles
                                 + ForwardRounds * (WaitLimit + DrainLimit + 8)
                                 + 6 * (DrainLimit + 6);
  localparam int WatchdogNs    = (TotalCycles * 4 + 500) * 10;

  // Outcome modes of the update stream
  localparam int AnyOutcome  = 0;
  localparam int AlwaysTaken = 1;
  localparam int NeverTaken  = 2;
  localparam int Alternate   = 3;
  localparam int AnyPc       = -1;

  logic               clk = 1'b0;
  logic               reset;
  logic               lookupValid;
  logic [PcWidth-1:0] lookupPc;
  logic               lookupReady;
  logic               fetchValid;
  logic               fetchTaken;
  counterT            fetchCounter;
  logic               creditReturn;
  logic               updateValid;
  logic               updateTaken;

  int   testId;
  logic testEnd;
  int   errorCount;
  int   checkCount;
  int   pending;

  // Fetch side bookkeeping of beats seen, updates sent and credits sent back
  int          delivered = 0;
  int          resolved;
  int          returned;
  logic [31:0] rngState;
  logic        altOutcome;

  always #5 clk = ~clk;

  bpredUnit #(.HistoryBits(HistoryBits), .UseGshare(UseGshare),
              .InFlightDepth(InFlightDepth), .Credits(Credits)) dut_i (
    .clk(clk), .reset(reset), .lookupValid(lookupValid), .lookupPc(lookupPc),
    .lookupReady(lookupReady), .fetchValid(fetchValid), .fetchTaken(fetchTaken),
    .fetchCounter(fetchCounter), .creditReturn(creditReturn),
    .updateValid(updateValid), .updateTaken(updateTaken));

  bpredChecker #(.HistoryBits(HistoryBits), .UseGshare(UseGshare),
                 .InFlightDepth(InFlightDepth), .Credits(Credits)) checker_i (
    .clk(clk), .reset(reset), .lookupValid(lookupValid), .lookupPc(lookupPc),
    .lookupReady(lookupReady), .fetchValid(fetchValid), .fetchTaken(fetchTaken),
    .fetchCounter(fetchCounter), .creditReturn(creditReturn), .updateValid(updateValid),
    .updateTaken(updateTaken), .testId(testId), .testEnd(testEnd),
    .errorCount(errorCount), .checkCount(checkCount), .pending(pending));

  // A beat counts at the falling edge before the rising edge that takes it
  always @(negedge clk) begin
    if (!reset && fetchValid) begin
      delivered++;
    end
  end

  function automatic logic [31:0] nextRandom();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  // Upper bits of the LCG are the better mixed ones
  function automatic int randomBelow(input int limit);
    return int'(nextRandom() >> 8) % limit;
  endfunction

  // Small set of branch addresses spread over the word address bits
  function automatic logic [PcWidth-1:0] branchPc(input int sel);
    case (sel)
      0:       return 32'h0000_1040;
      1:       return 32'h0000_20c8;
      2:       return 32'h0000_3a14;
      default: return 32'h0000_4ffc;
    endcase
  endfunction

  // Drives one cycle with an update only for a delivered branch and a credit only if owed
  task automatic driveCycle(input logic wantLookup, input logic [PcWidth-1:0] pc,
                            input logic wantUpdate, input logic taken,
                            input logic wantCredit, output logic sent);
    @(posedge clk);
    #1;
    lookupValid  = wantLookup;
    lookupPc     = pc;
    updateValid  = wantUpdate && (delivered > resolved);
    updateTaken  = taken;
    creditReturn = wantCredit && (delivered > returned);
    sent         = updateValid;
    if (updateValid) begin
      resolved++;
    end
    if (creditReturn) begin
      returned++;
    end
  endtask

  task automatic runTraffic(input int cycles, input int lookupPct, input int updatePct,
                            input int creditPct, input int pcSel, input int outcomeMode);
    logic [PcWidth-1:0] pc;
    logic               taken;
    logic               sent;
    for (int i = 0; i < cycles; i++) begin
      pc = branchPc((pcSel == AnyPc) ? randomBelow(4) : pcSel);
      case (outcomeMode)
        AlwaysTaken: taken = 1'b1;
        NeverTaken:  taken = 1'b0;
        Alternate:   taken = altOutcome;
        default:     taken = (randomBelow(2) == 1);
      endcase
      driveCycle(randomBelow(100) < lookupPct, pc, randomBelow(100) < updatePct, taken,
                 randomBelow(100) < creditPct, sent);
      if (sent) begin
        altOutcome = ~altOutcome;
      end
    end
  endtask

  // Deliver, resolve and return credits for everything still in flight
  task automatic drainAll();
    logic sent;
    int   n;
    n = 0;
    while ((pending != 0 || delivered != resolved || delivered != returned) && n < DrainLimit) begin
      driveCycle(1'b0, '0, 1'b1, randomBelow(2) == 1, 1'b1, sent);
      n++;
    end
    driveCycle(1'b0, '0, 1'b0, 1'b0, 1'b0, sent);
    driveCycle(1'b0, '0, 1'b0, 1'b0, 1'b0, sent);
  endtask

  task automatic closeTest();
    logic sent;
    driveCycle(1'b0, '0, 1'b0, 1'b0, 1'b0, sent);
    testEnd = 1'b1;
    driveCycle(1'b0, '0, 1'b0, 1'b0, 1'b0, sent);
    testEnd = 1'b0;
  endtask

  // One lookup, then its update in the same cycle as a second lookup of the same PC
  // No update lies between them, so both hit one table entry
  task automatic forwardRound(input logic taken);
    logic sent;
    int   n;
    driveCycle(1'b1, branchPc(2), 1'b0, 1'b0, 1'b1, sent);
    n = 0;
    while (delivered == resolved && n < WaitLimit) begin
      driveCycle(1'b0, '0, 1'b0, 1'b0, 1'b1, sent);
      n++;
    end
    driveCycle(1'b1, branchPc(2), 1'b1, taken, 1'b1, sent);
    drainAll();
  endtask

  initial begin
    reset        = 1'b1;
    lookupValid  = 1'b0;
    lookupPc     = '0;
    creditReturn = 1'b0;
    updateValid  = 1'b0;
    updateTaken  = 1'b0;
    testId       = 0;
    testEnd      = 1'b0;
    resolved     = 0;
    returned     = 0;
    rngState     = 32'hd2f0_7f77;
    altOutcome   = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    testId = 1;
    runTraffic(ShortCycles, 60, 0, 100, AnyPc, AnyOutcome);
    drainAll();
    closeTest();

    testId = 2;
    runTraffic(RandomCycles, 70, 60, 70, AnyPc, AnyOutcome);
    drainAll();
    closeTest();

    testId = 3;
    runTraffic(PhaseCycles, 80, 80, 90, 0, AlwaysTaken);
    runTraffic(PhaseCycles, 80, 80, 90, 0, NeverTaken);
    drainAll();
    closeTest();

    testId = 4;
    for (int r = 0; r < ForwardRounds; r++) begin
      forwardRound(r % 2 == 0);
    end
    closeTest();

    // Credits withheld first, so the queue fills and lookups back up
    testId = 5;
    runTraffic(PhaseCycles, 100, 50, 0, AnyPc, AnyOutcome);
    runTraffic(PhaseCycles, 100, 50, 100, AnyPc, AnyOutcome);
    drainAll();
    closeTest();

    testId = 6;
    runTraffic(4 * PhaseCycles, 70, 70, 90, 1, Alternate);
    drainAll();
    closeTest();

    $display("Summary: 6 tests, %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WatchdogNs);
    $display("Watchdog expired at %0t ns with test %0d still running", $time, testId);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
